// File: hw/ecc_pkg.sv
package ecc_pkg;

    // codeword container and the largest code's field sizes
    localparam int cw_w   = 32;
    localparam int info_w = 26;
    localparam int par_w  = 6;

    // mode encoding follows the encoder stage select, 2'b11 has no code
    typedef enum logic [1:0] {
        mode_8_4   = 2'b00,
        mode_16_11 = 2'b01,
        mode_32_26 = 2'b10
    } code_mode_t;

    // per-mode tables, last entry covers the illegal mode
    localparam int info_len [4] = '{4, 11, 26, 0};
    // parity length includes the overall bit
    localparam int par_len [4] = '{4, 5, 6, 0};
    localparam logic [info_w-1:0] info_mask [4] =
        '{26'h000000f, 26'h00007ff, 26'h3ffffff, 26'h0000000};
    // hamming bits only, overall bit excluded
    localparam logic [par_w-1:0] ham_mask [4] = '{6'h07, 6'h0f, 6'h1f, 6'h00};
    localparam logic [cw_w-1:0] used_mask [4] =
        '{32'h000000ff, 32'h0000ffff, 32'hffffffff, 32'h00000000};

    // row r selects the info bits feeding hamming parity bit r
    typedef logic [par_w-1:0][info_w-1:0] h_mat_t;

    localparam h_mat_t h_mat_8_4   = 156'hE0_0000_3400_000B;
    localparam h_mat_t h_mat_16_11 = 156'h1FC_0000_78E0_0019_B400_055B;
    localparam h_mat_t h_mat_32_26 = 156'h3_FFF8_00FF_01FC_3C3C_78EC_CCD9_B6AA_AD5B;

    typedef struct packed {
        logic              valid;
        code_mode_t        mode;
        logic [info_w-1:0] info;
    } enc_req_t;

    typedef struct packed {
        logic            valid;
        code_mode_t      mode;
        logic [cw_w-1:0] word;
    } codeword_t;

    typedef struct packed {
        logic             valid;
        code_mode_t       mode;
        logic [cw_w-1:0]  word;
        logic [par_w-1:0] syndrome;
        logic             overall;
    } dec_stage_t;

    typedef struct packed {
        logic              valid;
        code_mode_t        mode;
        logic [info_w-1:0] info;
        logic              corrected;
        logic              double_err;
    } dec_result_t;

    // illegal mode gives an all-zero matrix
    function automatic h_mat_t sel_h_mat(input code_mode_t mode);
        case (mode)
            mode_8_4:   return h_mat_8_4;
            mode_16_11: return h_mat_16_11;
            mode_32_26: return h_mat_32_26;
            default:    return '0;
        endcase
    endfunction

    // info field sits right above the parity bits
    function automatic logic [info_w-1:0] extract_info(
        input logic [cw_w-1:0] word,
        input code_mode_t      mode
    );
        logic [cw_w-1:0] shifted;
        shifted = word >> par_len[mode];
        return shifted[info_w-1:0] & info_mask[mode];
    endfunction

endpackage

// File: hw/gf2_mat_mult.sv
module gf2_mat_mult #(
    parameter int rows = ecc_pkg::par_w,
    parameter int cols = ecc_pkg::info_w
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [rows*cols-1:0] mat,
    input  logic [cols-1:0]      vec,
    output logic [rows-1:0]      prod
);

    logic [rows-1:0] prod_next;

    // over gf2 multiply is and, sum is xor
    always_comb begin
        for (int r = 0; r < rows; r++) begin
            // row r lives at [r*cols +: cols], column c at bit c
            prod_next[r] = ^(mat[r*cols +: cols] & vec);
        end
    end

    // one cycle from vec to prod
    always_ff @(posedge clk) begin
        if (rst) begin
            prod <= '0;
        end else begin
            prod <= prod_next;
        end
    end

endmodule

// File: hw/enc_stage_1.sv
module enc_stage_1 (
    input  logic               clk,
    input  logic               rst,
    input  ecc_pkg::enc_req_t  req,
    output ecc_pkg::codeword_t cw
);

    import ecc_pkg::*;

    h_mat_t            mat;
    logic [par_w-1:0]  parity;
    enc_req_t          req_q;
    logic [cw_w-1:0]   info_ext;
    logic [cw_w-1:0]   word_next;

    // matrix follows the incoming request
    assign mat = sel_h_mat(req.mode);

    // unused columns are zero so upper info bits drop out here
    gf2_mat_mult #(
        .rows(par_w),
        .cols(info_w)
    ) u_mult (
        .clk (clk),
        .rst (rst),
        .mat (mat),
        .vec (req.info),
        .prod(parity)
    );

    // request waits one cycle for its parity
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;
        end else begin
            req_q <= req;
        end
    end

    // overall row of every matrix is zero, so its slot stays clear
    assign info_ext  = {{(cw_w-info_w){1'b0}}, req_q.info & info_mask[req_q.mode]};
    assign word_next = (info_ext << par_len[req_q.mode]) | {{(cw_w-par_w){1'b0}}, parity};

    always_ff @(posedge clk) begin
        if (rst) begin
            cw <= '0;
        end else begin
            cw.valid <= req_q.valid;
            cw.mode  <= req_q.mode;
            cw.word  <= word_next;
        end
    end

    // fourth mode value has no code behind it
    a_legal_mode: assert property (@(posedge clk) disable iff (rst)
        req.valid |-> req.mode inside {mode_8_4, mode_16_11, mode_32_26});

endmodule

// File: hw/enc_stage_2.sv
module enc_stage_2 (
    input  logic               clk,
    input  logic               rst,
    input  ecc_pkg::codeword_t cw_in,
    output ecc_pkg::codeword_t cw_out
);

    import ecc_pkg::*;

    logic            overall;
    logic [cw_w-1:0] ovl_sel;

    // even parity over every used bit
    assign overall = ^(cw_in.word & used_mask[cw_in.mode]);
    // overall bit sits right above the hamming bits
    assign ovl_sel = cw_w'(1) << (par_len[cw_in.mode] - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cw_out <= '0;
        end else begin
            cw_out.valid <= cw_in.valid;
            cw_out.mode  <= cw_in.mode;
            cw_out.word  <= overall ? (cw_in.word | ovl_sel) : cw_in.word;
        end
    end

    // stage 1 leaves the overall slot empty for us
    a_ovl_clear: assert property (@(posedge clk) disable iff (rst)
        cw_in.valid |-> (cw_in.word & ovl_sel) == '0);

endmodule

// File: hw/dec_syndrome.sv
module dec_syndrome (
    input  logic                clk,
    input  logic                rst,
    input  ecc_pkg::codeword_t  cw,
    output ecc_pkg::dec_stage_t stage
);

    import ecc_pkg::*;

    h_mat_t            mat;
    logic [info_w-1:0] info_rx;
    logic [par_w-1:0]  parity_re;
    codeword_t         cw_q;
    logic              overall_q;

    assign mat     = sel_h_mat(cw.mode);
    assign info_rx = extract_info(cw.word, cw.mode);

    // parity recomputed from the received info
    gf2_mat_mult #(
        .rows(par_w),
        .cols(info_w)
    ) u_mult (
        .clk (clk),
        .rst (rst),
        .mat (mat),
        .vec (info_rx),
        .prod(parity_re)
    );

    // word and its overall xor line up with the product
    always_ff @(posedge clk) begin
        if (rst) begin
            cw_q      <= '0;
            overall_q <= 1'b0;
        end else begin
            cw_q      <= cw;
            overall_q <= ^(cw.word & used_mask[cw.mode]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else begin
            stage.valid    <= cw_q.valid;
            stage.mode     <= cw_q.mode;
            stage.word     <= cw_q.word;
            // received hamming bits only, overall bit masked off
            stage.syndrome <= parity_re ^ (cw_q.word[par_w-1:0] & ham_mask[cw_q.mode]);
            stage.overall  <= overall_q;
        end
    end

    // fourth mode value has no code behind it
    a_legal_mode: assert property (@(posedge clk) disable iff (rst)
        cw.valid |-> cw.mode inside {mode_8_4, mode_16_11, mode_32_26});

endmodule

// File: hw/dec_corrector.sv
module dec_corrector (
    input  logic                 clk,
    input  logic                 rst,
    input  ecc_pkg::dec_stage_t  stage,
    output ecc_pkg::dec_result_t result
);

    import ecc_pkg::*;

    h_mat_t            mat;
    logic [par_w-1:0]  col;
    logic [info_w-1:0] info_rx;
    logic [info_w-1:0] info_fix;
    logic              col_hit;
    logic              unit_hit;
    logic              syn_zero;
    logic              single_ok;
    logic              uncorrectable;

    assign mat      = sel_h_mat(stage.mode);
    assign info_rx  = extract_info(stage.word, stage.mode);
    assign syn_zero = (stage.syndrome == '0);
    // unit vector means a hamming parity bit flipped, info is fine
    assign unit_hit = $onehot(stage.syndrome);

    // look for the matrix column equal to the syndrome
    always_comb begin
        info_fix = info_rx;
        col_hit  = 1'b0;
        col      = '0;
        for (int c = 0; c < info_w; c++) begin
            for (int r = 0; r < par_w; r++) begin
                col[r] = mat[r][c];
            end
            if (c < info_len[stage.mode] && !syn_zero && col == stage.syndrome) begin
                info_fix[c] = ~info_fix[c];
                col_hit     = 1'b1;
            end
        end
    end

    // odd overall parity with a known syndrome is one flipped bit
    // zero syndrome there means the overall bit itself
    assign single_ok = stage.overall && (syn_zero || col_hit || unit_hit);
    // even overall with nonzero syndrome is a double error
    // an unmatched syndrome is treated the same way
    assign uncorrectable = !syn_zero && !single_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result.valid      <= stage.valid;
            result.mode       <= stage.mode;
            result.info       <= single_ok ? info_fix : info_rx;
            result.corrected  <= stage.valid && single_ok;
            result.double_err <= stage.valid && uncorrectable;
        end
    end

    // a syndrome bit above the hamming count would fake a unit-vector match
    a_syn_range: assert property (@(posedge clk) disable iff (rst)
        stage.valid |-> (stage.syndrome & ~ham_mask[stage.mode]) == '0);

endmodule

// File: hw/ecc_codec.sv
module ecc_codec (
    input  logic                 clk,
    input  logic                 rst,
    input  ecc_pkg::enc_req_t    enc_in,
    output ecc_pkg::codeword_t   enc_out,
    input  ecc_pkg::codeword_t   dec_in,
    output ecc_pkg::dec_result_t dec_out
);

    import ecc_pkg::*;

    codeword_t  enc_mid;
    dec_stage_t dec_mid;

    // encoder chain, three cycles
    enc_stage_1 u_enc_1 (
        .clk(clk),
        .rst(rst),
        .req(enc_in),
        .cw (enc_mid)
    );

    enc_stage_2 u_enc_2 (
        .clk   (clk),
        .rst   (rst),
        .cw_in (enc_mid),
        .cw_out(enc_out)
    );

    // decoder chain, three cycles
    dec_syndrome u_dec_syn (
        .clk  (clk),
        .rst  (rst),
        .cw   (dec_in),
        .stage(dec_mid)
    );

    dec_corrector u_dec_cor (
        .clk   (clk),
        .rst   (rst),
        .stage (dec_mid),
        .result(dec_out)
    );

endmodule

// File: testbench/tb_ecc_codec.sv
module tb_ecc_codec;

    import ecc_pkg::*;

    localparam int num_vec = 400;

    typedef struct packed {
        code_mode_t        mode;
        logic [info_w-1:0] info;
    } sent_t;

    typedef struct packed {
        code_mode_t        mode;
        logic [info_w-1:0] info;
        logic              corrected;
        logic              double_err;
    } dec_exp_t;

    logic        clk;
    logic        rst;
    enc_req_t    enc_in;
    codeword_t   enc_out;
    codeword_t   dec_in;
    dec_result_t dec_out;

    integer          seed;
    int              errors;
    int              sent;
    sent_t           enc_q [$];
    dec_exp_t        dec_q [$];
    code_mode_t      exp_enc_mode;
    logic [cw_w-1:0] exp_enc_word;
    dec_exp_t        exp_dec;

    ecc_codec UUT (
        .clk    (clk),
        .rst    (rst),
        .enc_in (enc_in),
        .enc_out(enc_out),
        .dec_in (dec_in),
        .dec_out(dec_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reference codeword built bit by bit from the layout rule
    function automatic logic [cw_w-1:0] encode_word(input code_mode_t mode,
                                                   input logic [info_w-1:0] info);
        h_mat_t          h;
        logic [cw_w-1:0] w;
        int              k;
        int              p;
        k = info_len[mode];
        p = par_len[mode];
        case (mode)
            mode_8_4:   h = h_mat_8_4;
            mode_16_11: h = h_mat_16_11;
            default:    h = h_mat_32_26;
        endcase
        w = '0;
        // hamming bit r in position r
        for (int r = 0; r < p - 1; r++) begin
            for (int c = 0; c < k; c++) begin
                w[r] = w[r] ^ (h[r][c] & info[c]);
            end
        end
        for (int c = 0; c < k; c++) begin
            w[p + c] = info[c];
        end
        // overall slot still zero, so xor of w is the needed bit
        w[p - 1] = ^w;
        return w;
    endfunction

    // each chain answers exactly three cycles after its strobe
    assert property (@(posedge clk) disable iff (rst) enc_in.valid |-> ##3 enc_out.valid)
        else begin
            errors++;
            $display("error enc_latency expected 1 actual 0");
        end
    assert property (@(posedge clk) disable iff (rst) enc_out.valid |-> $past(enc_in.valid, 3))
        else begin
            errors++;
            $display("encoder produced a result that was never requested");
        end
    assert property (@(posedge clk) disable iff (rst) dec_in.valid |-> ##3 dec_out.valid)
        else begin
            errors++;
            $display("error dec_latency expected 1 actual 0");
        end
    assert property (@(posedge clk) disable iff (rst) dec_out.valid |-> $past(dec_in.valid, 3))
        else begin
            errors++;
            $display("decoder produced a result that was never requested");
        end

    // codeword contents, padding and parity included
    assert property (@(posedge clk) disable iff (rst)
        enc_out.valid |-> enc_out.word == exp_enc_word)
        else begin
            errors++;
            $display("error enc_word expected %h actual %h", exp_enc_word,
                     $sampled(enc_out.word));
        end
    assert property (@(posedge clk) disable iff (rst)
        enc_out.valid |-> enc_out.mode == exp_enc_mode)
        else begin
            errors++;
            $display("error enc_mode expected %0d actual %0d", exp_enc_mode,
                     $sampled(enc_out.mode));
        end
    assert property (@(posedge clk) disable iff (rst) enc_out.valid |-> (^enc_out.word) == 1'b0)
        else begin
            errors++;
            $display("error enc_even_parity expected 0 actual 1");
        end

    // decoded info, mode and flags against the injected flips
    assert property (@(posedge clk) disable iff (rst)
        dec_out.valid |-> dec_out.info == exp_dec.info)
        else begin
            errors++;
            $display("error dec_info expected %h actual %h", exp_dec.info,
                     $sampled(dec_out.info));
        end
    assert property (@(posedge clk) disable iff (rst)
        dec_out.valid |-> dec_out.mode == exp_dec.mode)
        else begin
            errors++;
            $display("error dec_mode expected %0d actual %0d", exp_dec.mode,
                     $sampled(dec_out.mode));
        end
    assert property (@(posedge clk) disable iff (rst)
        dec_out.valid |-> dec_out.corrected == exp_dec.corrected)
        else begin
            errors++;
            $display("error dec_corrected expected %b actual %b", exp_dec.corrected,
                     $sampled(dec_out.corrected));
        end
    assert property (@(posedge clk) disable iff (rst)
        dec_out.valid |-> dec_out.double_err == exp_dec.double_err)
        else begin
            errors++;
            $display("error dec_double_err expected %b actual %b", exp_dec.double_err,
                     $sampled(dec_out.double_err));
        end

    // run length bounded by the vector count
    initial begin
        repeat (20 + 8 * num_vec) @(posedge clk);
        $display("watchdog expired, results stopped arriving after %0d vectors", sent);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        sent_t           item;
        dec_exp_t        dexp;
        logic [cw_w-1:0] flips;
        logic [cw_w-1:0] bad;
        int              m;
        int              nflip;
        int              width;
        int              pos_a;
        int              pos_b;
        seed = 32'h65dd3bf4;
        errors = 0;
        sent = 0;
        rst = 1'b1;
        enc_in = '0;
        dec_in = '0;
        exp_enc_mode = mode_8_4;
        exp_enc_word = '0;
        exp_dec = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (sent < num_vec || enc_q.size() != 0 || dec_q.size() != 0) begin
            @(negedge clk);
            // outputs of the last rising edge are stable here
            if (dec_out.valid) begin
                if (dec_q.size() == 0) begin
                    errors++;
                    $display("decoder output arrived with no codeword outstanding");
                end else begin
                    exp_dec = dec_q.pop_front();
                end
            end
            dec_in = '0;
            if (enc_out.valid) begin
                if (enc_q.size() == 0) begin
                    errors++;
                    $display("encoder output arrived with no request outstanding");
                end else begin
                    item = enc_q.pop_front();
                    exp_enc_mode = item.mode;
                    exp_enc_word = encode_word(item.mode, item.info);
                    // zero, one or two distinct flips inside the used width
                    width = info_len[item.mode] + par_len[item.mode];
                    nflip = $unsigned($random(seed)) % 3;
                    pos_a = $unsigned($random(seed)) % width;
                    pos_b = (pos_a + 1 + $unsigned($random(seed)) % (width - 1)) % width;
                    flips = '0;
                    if (nflip >= 1) flips[pos_a] = 1'b1;
                    if (nflip == 2) flips[pos_b] = 1'b1;
                    dec_in.valid = 1'b1;
                    dec_in.mode = item.mode;
                    dec_in.word = enc_out.word ^ flips;
                    dexp.mode = item.mode;
                    dexp.info = item.info;
                    dexp.corrected = (nflip == 1);
                    dexp.double_err = (nflip == 2);
                    // double errors pass the received info field unchanged
                    if (nflip == 2) begin
                        bad = exp_enc_word ^ flips;
                        for (int c = 0; c < info_len[item.mode]; c++) begin
                            dexp.info[c] = bad[par_len[item.mode] + c];
                        end
                    end
                    dec_q.push_back(dexp);
                end
            end
            // new request about three cycles in four, modes mixed
            enc_in = '0;
            if (sent < num_vec && ($random(seed) & 3) != 0) begin
                m = $unsigned($random(seed)) % 3;
                item.mode = code_mode_t'(m);
                item.info = $random(seed) & ((26'(1) << info_len[item.mode]) - 1);
                enc_in.valid = 1'b1;
                enc_in.mode = item.mode;
                enc_in.info = item.info;
                enc_q.push_back(item);
                sent++;
            end
        end
        // let the last decoder checks fire
        @(posedge clk);
        @(negedge clk);
        $display("vectors sent: %0d, errors: %0d", sent, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: ecc_codec.f
hw/ecc_pkg.sv
hw/gf2_mat_mult.sv
hw/enc_stage_1.sv
hw/enc_stage_2.sv
hw/dec_syndrome.sv
hw/dec_corrector.sv
hw/ecc_codec.sv
testbench/tb_ecc_codec.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_ecc_codec
FLIST     := ecc_codec.f
FLAGS     := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Done: no errors
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
